// ==== source/dso_params.svh ====
`ifndef DSO_PARAMS_SVH
`define DSO_PARAMS_SVH

// frame geometry
`define DSO_HORIZONTAL 64   // samples per frame, 640 also fits
`define DSO_ADDR_W     6    // one bank, 2**DSO_ADDR_W >= DSO_HORIZONTAL

// APB bus
`define DSO_PADDR_W    12
`define DSO_PDATA_W    32

`endif

// ==== source/dso_cfg_pkg.sv ====
package dso_cfg_pkg;

  // ****************************************
  // register map
  // ****************************************
  typedef enum logic [11:0] {
    CTRL      = 12'h000,  // run, edge, rearm
    LEVEL     = 12'h004,  // trigger level
    SHIFT     = 12'h008,  // {dir, magnitude}
    STATUS    = 12'h00C,  // frame_ready, bank
    WAVE_BASE = 12'h400   // pixel x at WAVE_BASE + 4x
  } reg_offset_e;

  // ****************************************
  // field positions
  // ****************************************
  typedef enum logic [1:0] {
    RUN       = 2'd0,
    EDGE_RISE = 2'd1,
    REARM     = 2'd2      // write-one pulse, reads 0
  } ctrl_bit_e;

  typedef enum logic [1:0] {
    FRAME_READY = 2'd0,
    BANK        = 2'd1    // bank being written
  } status_bit_e;

endpackage

// ==== source/dso_wave_pkg.sv ====
package dso_wave_pkg;

  // one decimated ADC sample
  typedef logic [7:0] sample_t;

  // value shown for pixels shifted off the frame
  localparam sample_t SAMPLE_OUTRANGE = 8'd255;

  typedef enum logic {
    FALLING = 1'b0,
    RISING  = 1'b1
  } trig_edge_e;

  // capture sequence of one frame
  typedef enum logic [1:0] {
    PRE_FILL  = 2'd0,  // half frame before trigger
    ARMED     = 2'd1,  // waiting for crossing
    POST_FILL = 2'd2,  // half frame after trigger
    DONE      = 2'd3   // frame held until rearm
  } cap_state_e;

endpackage

// ==== source/dso_apb_regs.sv ====
`timescale 1ns/1ns
`include "dso_params.svh"

module dso_apb_regs (
  input  logic                       ad_clk,
  input  logic                       rstn,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`DSO_PADDR_W-1:0]    paddr,
  input  logic [`DSO_PDATA_W-1:0]    pwdata,
  output logic [`DSO_PDATA_W-1:0]    prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       run,
  output dso_wave_pkg::trig_edge_e   trig_edge,
  output dso_wave_pkg::sample_t      trig_level,
  output logic [`DSO_ADDR_W:0]       h_shift,
  output logic                       rearm,
  output logic                       pix_rd,
  output logic [`DSO_ADDR_W-1:0]     pix_idx,
  input  dso_wave_pkg::sample_t      pix_data,
  input  logic                       frame_ready,
  input  logic                       bank
);

  localparam int IDX_W = `DSO_PADDR_W - 2;

  logic                    access;
  logic                    wave_sel;
  logic [`DSO_PADDR_W-1:0] wave_off;
  logic [IDX_W-1:0]        idx_full;
  logic                    wave_rd_ok;
  logic                    reg_hit;
  logic                    wave_wait;
  logic                    wr_ok;

  // ****************************************
  // address decode
  // ****************************************
  assign access     = psel & penable;
  assign wave_sel   = paddr >= dso_cfg_pkg::WAVE_BASE;
  assign wave_off   = paddr - dso_cfg_pkg::WAVE_BASE;
  assign idx_full   = wave_off[`DSO_PADDR_W-1:2];   // word index in window
  assign pix_idx    = idx_full[`DSO_ADDR_W-1:0];
  assign wave_rd_ok = wave_sel && !pwrite && (wave_off[1:0] == 2'b00) &&
                      (idx_full < `DSO_HORIZONTAL);

  // one wait state for pixel reads, none otherwise
  assign pix_rd  = access & wave_rd_ok & ~wave_wait;
  assign pready  = access & (~wave_rd_ok | wave_wait);
  assign pslverr = access & ~wave_rd_ok & ~reg_hit;
  assign wr_ok   = access & pwrite & reg_hit;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wave_wait <= 1'b0;
    end else begin
      wave_wait <= pix_rd;   // memory data lands next cycle
    end
  end

  // ****************************************
  // control registers
  // ****************************************
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      run        <= 1'b0;
      trig_edge  <= dso_wave_pkg::RISING;
      trig_level <= 8'h80;   // mid scale
      h_shift    <= '0;
      rearm      <= 1'b0;
    end else begin
      rearm <= 1'b0;
      if (wr_ok) begin
        case (paddr)
          dso_cfg_pkg::CTRL: begin
            run       <= pwdata[dso_cfg_pkg::RUN];
            trig_edge <= dso_wave_pkg::trig_edge_e'(pwdata[dso_cfg_pkg::EDGE_RISE]);
            rearm     <= pwdata[dso_cfg_pkg::REARM];   // single-cycle pulse
          end
          dso_cfg_pkg::LEVEL: trig_level <= pwdata[7:0];
          dso_cfg_pkg::SHIFT: h_shift <= pwdata[`DSO_ADDR_W:0];
          default: ;   // STATUS is read only
        endcase
      end
    end
  end

  // read mux, also flags the mapped registers
  always_comb begin
    prdata  = '0;
    reg_hit = 1'b1;
    case (paddr)
      dso_cfg_pkg::CTRL: begin
        prdata[dso_cfg_pkg::RUN]       = run;
        prdata[dso_cfg_pkg::EDGE_RISE] = trig_edge;
      end
      dso_cfg_pkg::LEVEL: prdata[7:0] = trig_level;
      dso_cfg_pkg::SHIFT: prdata[`DSO_ADDR_W:0] = h_shift;
      dso_cfg_pkg::STATUS: begin
        prdata[dso_cfg_pkg::FRAME_READY] = frame_ready;
        prdata[dso_cfg_pkg::BANK]        = bank;
      end
      default: begin
        reg_hit = 1'b0;
        if (wave_rd_ok) begin
          prdata[7:0] = pix_data;
        end
      end
    endcase
  end

endmodule

// ==== source/dso_trig_detect.sv ====
`timescale 1ns/1ns

module dso_trig_detect (
  input  logic                     ad_clk,
  input  logic                     rstn,
  input  dso_wave_pkg::sample_t    ad_data,
  input  logic                     deci_valid,
  input  dso_wave_pkg::sample_t    trig_level,
  input  dso_wave_pkg::trig_edge_e trig_edge,
  input  logic                     trig_en,
  output logic                     trig_hit
);

  dso_wave_pkg::sample_t s0;   // newest
  dso_wave_pkg::sample_t s1;   // crossing sample
  dso_wave_pkg::sample_t s2;
  dso_wave_pkg::sample_t s3;   // oldest
  logic                  fresh;
  logic                  rise_x;
  logic                  fall_x;

  // ****************************************
  // sample history
  // ****************************************
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      s0    <= '0;
      s1    <= '0;
      s2    <= '0;
      s3    <= '0;
      fresh <= 1'b0;
    end else begin
      fresh <= deci_valid;   // history moved this edge
      if (deci_valid) begin
        s0 <= ad_data;
        s1 <= s0;
        s2 <= s1;
        s3 <= s2;
      end
    end
  end

  // ****************************************
  // level crossing
  // ****************************************
  // two samples on each side of the level keep noise from retriggering
  assign rise_x = (s3 < trig_level) && (s2 < trig_level) &&
                  (s1 >= trig_level) && (s0 > trig_level);
  assign fall_x = (s3 > trig_level) && (s2 > trig_level) &&
                  (s1 <= trig_level) && (s0 < trig_level);

  // high for the one cycle after s0 arrives
  assign trig_hit = fresh && trig_en &&
                    ((trig_edge == dso_wave_pkg::RISING) ? rise_x : fall_x);

endmodule

// ==== source/dso_capture_buf.sv ====
`timescale 1ns/1ns
`include "dso_params.svh"

module dso_capture_buf (
  input  logic                    ad_clk,
  input  logic                    rstn,
  input  dso_wave_pkg::sample_t   ad_data,
  input  logic                    deci_valid,
  input  logic                    run,
  input  logic                    trig_hit,
  input  logic                    rearm,
  output logic                    trig_en,
  output logic                    frame_ready,
  output logic                    bank,
  output logic [`DSO_ADDR_W-1:0]  frame_trig,
  input  logic [`DSO_ADDR_W-1:0]  rd_addr,
  output dso_wave_pkg::sample_t   rd_data
);

  localparam int H  = `DSO_HORIZONTAL;
  localparam int AW = `DSO_ADDR_W;

  dso_wave_pkg::cap_state_e state;
  dso_wave_pkg::sample_t    mem [2**(AW+1)];   // bank bit on top
  logic [AW-1:0]            wr_addr;
  logic [AW-1:0]            fill_cnt;
  logic [AW-1:0]            trig_pos;
  logic [AW-1:0]            stop_addr;
  logic                     wr_en;

  // a + d modulo frame length, d below H
  function automatic logic [AW-1:0] wrap_add(input logic [AW-1:0] a, input int unsigned d);
    int unsigned s;
    s = a + d;
    if (s >= H) begin
      s = s - H;
    end
    return AW'(s);
  endfunction

  assign wr_en       = deci_valid && run && (state != dso_wave_pkg::DONE);
  assign trig_en     = run && (state == dso_wave_pkg::ARMED);
  assign frame_ready = (state == dso_wave_pkg::DONE);

  // ****************************************
  // capture sequence
  // ****************************************
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= dso_wave_pkg::PRE_FILL;
      wr_addr    <= '0;
      fill_cnt   <= '0;
      bank       <= 1'b0;
      frame_trig <= '0;
    end else begin
      if (wr_en) begin
        wr_addr <= wrap_add(wr_addr, 1);   // circular within one bank
      end
      case (state)
        dso_wave_pkg::PRE_FILL: begin
          if (wr_en) begin
            if (fill_cnt == AW'(H / 2 - 1)) begin
              state    <= dso_wave_pkg::ARMED;
              fill_cnt <= '0;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
            end
          end
        end
        dso_wave_pkg::ARMED: begin
          if (trig_hit) begin
            state <= dso_wave_pkg::POST_FILL;
          end
        end
        dso_wave_pkg::POST_FILL: begin
          if (wr_en && (wr_addr == stop_addr)) begin
            state <= dso_wave_pkg::DONE;   // last sample of the window
          end
        end
        default: begin
          if (rearm) begin
            state      <= dso_wave_pkg::PRE_FILL;
            bank       <= ~bank;      // finished frame goes to the reader
            frame_trig <= trig_pos;
          end
        end
      endcase
    end
  end

  // s1 was written two addresses back when the hit shows up
  always_ff @(posedge ad_clk) begin
    if (trig_hit) begin
      trig_pos  <= wrap_add(wr_addr, H - 2);
      stop_addr <= wrap_add(wr_addr, H / 2 - 3);   // trig_pos + H/2 - 1
    end
  end

  // ****************************************
  // ping-pong memory
  // ****************************************
  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[{bank, wr_addr}] <= ad_data;
    end
  end

  always_ff @(posedge ad_clk) begin
    rd_data <= mem[{~bank, rd_addr}];   // reader always sees the idle bank
  end

endmodule

// ==== source/dso_wave_reader.sv ====
`timescale 1ns/1ns
`include "dso_params.svh"

module dso_wave_reader (
  input  logic                    ad_clk,
  input  logic                    rstn,
  input  logic                    pix_rd,
  input  logic [`DSO_ADDR_W-1:0]  pix_idx,
  input  logic [`DSO_ADDR_W:0]    h_shift,
  input  logic [`DSO_ADDR_W-1:0]  frame_trig,
  output logic [`DSO_ADDR_W-1:0]  rd_addr,
  input  dso_wave_pkg::sample_t   rd_data,
  output dso_wave_pkg::sample_t   pix_data
);

  localparam int H  = `DSO_HORIZONTAL;
  localparam int AW = `DSO_ADDR_W;

  logic          shift_right;
  logic [AW-1:0] shift_mag;
  logic [AW:0]   off;
  logic [AW+1:0] pos;
  logic [AW+1:0] pos_wrap;
  logic          out_range;
  logic          out_range_q;

  assign shift_right = h_shift[AW];   // 1 moves the trace right
  assign shift_mag   = h_shift[AW-1:0];

  // ****************************************
  // read address
  // ****************************************
  // pixel 0 sits H/2 before the trigger, and -H/2 equals +H/2 mod H
  assign off = shift_right ? ({1'b0, pix_idx} - shift_mag) : ({1'b0, pix_idx} + shift_mag);
  assign pos = (AW+2)'(frame_trig) + (AW+2)'(H / 2) + (AW+2)'(off);

  // in-range pixels stay below 3H, so two folds are enough
  always_comb begin
    if (pos >= (AW+2)'(2 * H)) begin
      pos_wrap = pos - (AW+2)'(2 * H);
    end else if (pos >= (AW+2)'(H)) begin
      pos_wrap = pos - (AW+2)'(H);
    end else begin
      pos_wrap = pos;
    end
  end

  assign rd_addr = pos_wrap[AW-1:0];

  // ****************************************
  // range check
  // ****************************************
  assign out_range = shift_right ? (pix_idx < shift_mag) : (pix_idx + shift_mag > H - 1);

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      out_range_q <= 1'b0;
    end else if (pix_rd) begin
      out_range_q <= out_range;   // lines up with registered rd_data
    end
  end

  assign pix_data = out_range_q ? dso_wave_pkg::SAMPLE_OUTRANGE : rd_data;

endmodule

// ==== source/dso_store_top.sv ====
`timescale 1ns/1ns
`include "dso_params.svh"

module dso_store_top (
  input  logic                     ad_clk,
  input  logic                     rstn,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`DSO_PADDR_W-1:0]  paddr,
  input  logic [`DSO_PDATA_W-1:0]  pwdata,
  output logic [`DSO_PDATA_W-1:0]  prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  dso_wave_pkg::sample_t    ad_data,
  input  logic                     deci_valid
);

  // ****************************************
  // control from registers
  // ****************************************
  logic                     run;
  dso_wave_pkg::trig_edge_e trig_edge;
  dso_wave_pkg::sample_t    trig_level;
  logic [`DSO_ADDR_W:0]     h_shift;
  logic                     rearm;

  // ****************************************
  // sample path and pixel reads
  // ****************************************
  logic                     trig_en;
  logic                     trig_hit;
  logic                     frame_ready;
  logic                     bank;
  logic [`DSO_ADDR_W-1:0]   frame_trig;
  logic                     pix_rd;
  logic [`DSO_ADDR_W-1:0]   pix_idx;
  dso_wave_pkg::sample_t    pix_data;
  logic [`DSO_ADDR_W-1:0]   rd_addr;
  dso_wave_pkg::sample_t    rd_data;

  dso_apb_regs i_apb_regs (
    .ad_clk      (ad_clk),
    .rstn        (rstn),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .run         (run),
    .trig_edge   (trig_edge),
    .trig_level  (trig_level),
    .h_shift     (h_shift),
    .rearm       (rearm),
    .pix_rd      (pix_rd),
    .pix_idx     (pix_idx),
    .pix_data    (pix_data),
    .frame_ready (frame_ready),
    .bank        (bank)
  );

  dso_trig_detect i_trig_detect (
    .ad_clk     (ad_clk),
    .rstn       (rstn),
    .ad_data    (ad_data),
    .deci_valid (deci_valid),
    .trig_level (trig_level),
    .trig_edge  (trig_edge),
    .trig_en    (trig_en),
    .trig_hit   (trig_hit)
  );

  dso_capture_buf i_capture_buf (
    .ad_clk      (ad_clk),
    .rstn        (rstn),
    .ad_data     (ad_data),
    .deci_valid  (deci_valid),
    .run         (run),
    .trig_hit    (trig_hit),
    .rearm       (rearm),
    .trig_en     (trig_en),
    .frame_ready (frame_ready),
    .bank        (bank),
    .frame_trig  (frame_trig),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  dso_wave_reader i_wave_reader (
    .ad_clk     (ad_clk),
    .rstn       (rstn),
    .pix_rd     (pix_rd),
    .pix_idx    (pix_idx),
    .h_shift    (h_shift),
    .frame_trig (frame_trig),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .pix_data   (pix_data)
  );

endmodule

// ==== test/dso_store_sva.sv ====
`timescale 1ns/1ns

module dso_store_sva (
  input logic ad_clk,
  input logic rstn,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic frame_ready,
  input logic rearm,
  input logic pix_rd
);

  // ****************************************
  // APB handshake
  // ****************************************
  ready_in_access: assert property (@(posedge ad_clk) disable iff (!rstn)
    pready |-> (psel && penable))
    else $error("pready outside an access phase");

  err_with_ready: assert property (@(posedge ad_clk) disable iff (!rstn)
    pslverr |-> pready)
    else $error("pslverr without pready");

  // pixel read ends after exactly one wait state
  pix_done: assert property (@(posedge ad_clk) disable iff (!rstn)
    pix_rd |=> pready)
    else $error("pixel read not complete one cycle after it started");

  // ****************************************
  // capture
  // ****************************************
  ready_held: assert property (@(posedge ad_clk) disable iff (!rstn)
    $fell(frame_ready) |-> $past(rearm))
    else $error("frame_ready dropped without a rearm write");

endmodule

bind dso_store_top dso_store_sva i_sva (
  .ad_clk      (ad_clk),
  .rstn        (rstn),
  .psel        (psel),
  .penable     (penable),
  .pready      (pready),
  .pslverr     (pslverr),
  .frame_ready (frame_ready),
  .rearm       (rearm),
  .pix_rd      (pix_rd)
);

// ==== test/dso_store_tb.sv ====
`timescale 1ns/1ns
`include "dso_params.svh"

module dso_store_tb;

  localparam int H         = `DSO_HORIZONTAL;
  localparam int TIMEOUT   = 16 * H;   // cycles per wait
  localparam int LEVEL_MID = 128;

  logic                    ad_clk;
  logic                    rstn;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`DSO_PADDR_W-1:0] paddr;
  logic [`DSO_PDATA_W-1:0] pwdata;
  logic [`DSO_PDATA_W-1:0] prdata;
  logic                    pready;
  logic                    pslverr;
  logic [7:0]              ad_data;
  logic                    deci_valid;

  logic [31:0] rng;
  int          hist[$];      // every valid sample sent, run or not
  int          cap_start;    // first sample of the frame being captured
  int          shown_start;
  int          shown_end;
  bit          shown_rise;
  logic        exp_bank;
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  dso_store_top i_dut (
    .ad_clk     (ad_clk),
    .rstn       (rstn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .ad_data    (ad_data),
    .deci_valid (deci_valid)
  );

  always #5 ad_clk = ~ad_clk;

  // ****************************************
  // reference model
  // ****************************************
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 1 ramp up through mid scale, 2 high/low steps with an early dip
  function automatic int sample_value(input int kind, input int i, input int noise);
    int v;
    case (kind)
      1: v = LEVEL_MID + 4 * (i - 3 * H / 4) + noise;
      2: begin
        if ((i >= 8 && i < 16) || i >= H / 2 + 10) begin
          v = 50 + noise;
        end else begin
          v = 200 - noise;
        end
      end
      default: v = noise * 64 + i % 64;
    endcase
    if (v < 0) begin
      v = 0;
    end
    return (v > 255) ? 255 : v;
  endfunction

  // k is the newest sample, k-1 the crossing one
  function automatic bit crossing(input int k, input bit rise);
    int s0, s1, s2, s3;
    s0 = hist[k];
    s1 = hist[k-1];
    s2 = hist[k-2];
    s3 = hist[k-3];
    if (rise) begin
      return s3 < LEVEL_MID && s2 < LEVEL_MID && s1 >= LEVEL_MID && s0 > LEVEL_MID;
    end
    return s3 > LEVEL_MID && s2 > LEVEL_MID && s1 <= LEVEL_MID && s0 < LEVEL_MID;
  endfunction

  function automatic int pixel_ref(input int x, input int m, input bit right);
    int k;
    int trig;
    trig = -1;
    // no hit before the half-frame prefill is complete
    for (k = shown_start + H / 2 - 1; k < shown_end && trig < 0; k++) begin
      if (crossing(k, shown_rise)) begin
        trig = k - 1;
      end
    end
    if (trig < 0) begin
      return -1;
    end
    if (right ? (x < m) : (x + m > H - 1)) begin
      return 255;   // shifted off the frame
    end
    return hist[trig - H / 2 + (right ? x - m : x + m)];
  endfunction

  // ****************************************
  // checking
  // ****************************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
      abort_run("DUT response differs from the reference");
    end
  endtask

  task automatic queue_compare(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  always @(posedge ad_clk) begin : compare
    string       nm;
    logic [31:0] e;
    logic [31:0] a;
    while (exp_q.size() > 0) begin
      nm = name_q.pop_front();
      e  = exp_q.pop_front();
      a  = act_q.pop_front();
      check(nm, e, a);
    end
  end

  // ****************************************
  // APB and sample drivers
  // ****************************************
  // looks at pready between the falling and the rising edge
  task automatic wait_pready();
    int n;
    n = 0;
    #1;
    while (!pready) begin
      @(negedge ad_clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        abort_run("APB slave never raised pready");
      end
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic slverr);
    @(negedge ad_clk);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge ad_clk);
    penable = 1'b1;
    wait_pready();
    slverr = pslverr;
    @(negedge ad_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(negedge ad_clk);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(negedge ad_clk);
    penable = 1'b1;
    wait_pready();
    data   = prdata;
    slverr = pslverr;
    @(negedge ad_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_expect(input string name, input logic [11:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    logic        slverr;
    apb_read(addr, data, slverr);
    queue_compare(name, exp, data);
    queue_compare({name, " pslverr"}, 32'd0, 32'(slverr));
  endtask

  // random gaps on deci_valid, optionally stops at frame_ready
  task automatic stream_samples(input int kind, input int count, input bit until_ready);
    int i;
    int n;
    bit done;
    i    = 0;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge ad_clk);
      rng = lcg_step(rng);
      n++;
      if (!until_ready) begin
        queue_compare("run off frame_ready", 32'd0, 32'(i_dut.frame_ready));
      end
      if (until_ready && i_dut.frame_ready) begin
        done = 1'b1;
      end else if (i >= count || n > TIMEOUT) begin
        if (until_ready) begin
          abort_run("frame_ready did not rise within the sample budget");
        end
        done = 1'b1;
      end else if (rng[31:30] != 2'b00) begin
        deci_valid = 1'b1;
        ad_data    = 8'(sample_value(kind, i, int'(rng[17:16])));
        hist.push_back(int'(ad_data));
        i++;
      end else begin
        deci_valid = 1'b0;
      end
    end
    deci_valid = 1'b0;
  endtask

  task automatic capture_frame(input string name, input int kind, input bit rise);
    logic slverr;
    apb_write(dso_cfg_pkg::LEVEL, 32'(LEVEL_MID), slverr);
    apb_write(dso_cfg_pkg::CTRL, {30'd0, rise, 1'b1}, slverr);
    cap_start = hist.size();
    stream_samples(kind, 4 * H, 1'b1);
    reg_expect({name, " status done"}, dso_cfg_pkg::STATUS, {30'd0, exp_bank, 1'b1});
    apb_write(dso_cfg_pkg::CTRL, {29'd0, 1'b1, rise, 1'b1}, slverr);
    exp_bank    = ~exp_bank;   // finished frame moves to the reader
    shown_start = cap_start;
    shown_end   = hist.size();
    shown_rise  = rise;
    reg_expect({name, " status rearmed"}, dso_cfg_pkg::STATUS, {30'd0, exp_bank, 1'b0});
  endtask

  task automatic read_frame(input string name, input int m, input bit right);
    int          x;
    logic [31:0] data;
    logic        slverr;
    apb_write(dso_cfg_pkg::SHIFT, 32'(m) | (32'(right) << `DSO_ADDR_W), slverr);
    for (x = 0; x < H; x++) begin
      apb_read(12'(dso_cfg_pkg::WAVE_BASE + 4 * x), data, slverr);
      queue_compare(name, 32'(pixel_ref(x, m, right)), data);
      queue_compare({name, " pslverr"}, 32'd0, 32'(slverr));
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    int          n;
    logic [31:0] data;
    logic        slverr;
    ad_clk     = 1'b0;
    rstn       = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    ad_data    = '0;
    deci_valid = 1'b0;
    rng        = 32'hc37e_3ad0;
    exp_bank   = 1'b0;
    cap_start  = 0;
    repeat (5) @(negedge ad_clk);
    rstn = 1'b1;

    // reset values, then read back
    reg_expect("ctrl reset", dso_cfg_pkg::CTRL, 32'h2);
    reg_expect("level reset", dso_cfg_pkg::LEVEL, 32'h80);
    reg_expect("shift reset", dso_cfg_pkg::SHIFT, 32'h0);
    reg_expect("status reset", dso_cfg_pkg::STATUS, 32'h0);
    apb_write(dso_cfg_pkg::LEVEL, 32'h5a, slverr);
    apb_write(dso_cfg_pkg::SHIFT, 32'h45, slverr);
    apb_write(dso_cfg_pkg::CTRL, 32'h1, slverr);
    reg_expect("level readback", dso_cfg_pkg::LEVEL, 32'h5a);
    reg_expect("shift readback", dso_cfg_pkg::SHIFT, 32'h45);
    reg_expect("ctrl readback", dso_cfg_pkg::CTRL, 32'h1);
    apb_write(dso_cfg_pkg::CTRL, 32'h2, slverr);

    // error responses
    apb_read(12'h010, data, slverr);
    queue_compare("unmapped read pslverr", 32'd1, 32'(slverr));
    apb_read(12'(dso_cfg_pkg::WAVE_BASE + 4 * H), data, slverr);
    queue_compare("pixel range pslverr", 32'd1, 32'(slverr));
    apb_write(dso_cfg_pkg::WAVE_BASE, 32'h0, slverr);
    queue_compare("wave write pslverr", 32'd1, 32'(slverr));

    // RUN cleared, early REARM ignored
    stream_samples(0, 4 * H, 1'b0);
    reg_expect("status run off", dso_cfg_pkg::STATUS, 32'h0);
    apb_write(dso_cfg_pkg::CTRL, 32'h6, slverr);
    reg_expect("status early rearm", dso_cfg_pkg::STATUS, 32'h0);

    capture_frame("rise", 1, 1'b1);
    read_frame("rise frame", 0, 1'b0);
    capture_frame("fall", 2, 1'b0);
    read_frame("fall frame", 0, 1'b0);
    read_frame("left shift", 5, 1'b0);
    read_frame("right shift", 9, 1'b1);

    n = 0;
    while (exp_q.size() > 0 && n < 10) begin
      @(negedge ad_clk);
      n++;
    end
    if (exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("compare queue never drained");
    end
  end

endmodule

// ==== dso_store.f ====
+incdir+source
source/dso_cfg_pkg.sv
source/dso_wave_pkg.sv
source/dso_apb_regs.sv
source/dso_trig_detect.sv
source/dso_capture_buf.sv
source/dso_wave_reader.sv
source/dso_store_top.sv
test/dso_store_sva.sv
test/dso_store_tb.sv

// ==== Makefile ====
# Verilator simulation of the dso_store sample-capture stage

VERILATOR ?= verilator
TOP       ?= dso_store_tb
FILELIST  ?= dso_store.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the run exits non-zero on $fatal or a failed assertion
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
